// ==== rtl/hc_cfg.svh ====
// Host channel driver configuration
`ifndef HC_CFG_SVH
`define HC_CFG_SVH

// Link widths
`define HC_DATA_WIDTH 64
`define HC_ADDR_WIDTH 32
`define HC_TAG_WIDTH 8

// Lines in each host ring buffer
`define HC_RING_LINES 16
// Client receive buffer depth, which is also the read credit limit
`define HC_RX_BUF_DEPTH 4
`define HC_MAX_WR_OUT 8

`endif

// ==== rtl/hc_bus_pkg.sv ====
// Host link bus types
`include "hc_cfg.svh"

package hc_bus_pkg;

    // One data line as carried on both link channels
    typedef logic [`HC_DATA_WIDTH-1:0] t_line;

    // Outgoing request header, shared by the read and the write channel
    typedef struct packed {
        logic [`HC_ADDR_WIDTH-1:0] addr;
        logic [`HC_TAG_WIDTH-1:0]  tag;
    } t_tx_hdr;

    // ------------------------------------------------------------
    // Received header word on channel 0
    // ------------------------------------------------------------

    // Read response view where the tag comes back as it was sent
    typedef struct packed {
        logic [15-`HC_TAG_WIDTH:0] rsvd;
        logic [`HC_TAG_WIDTH-1:0]  tag;
    } t_rx_rd_view;

    // Configuration write view carrying a 10 bit CSR index
    typedef struct packed {
        logic [5:0] rsvd;
        logic [9:0] csr_idx;
    } t_rx_cfg_view;

    // The valid that arrives with the word picks the view
    typedef union packed {
        t_rx_rd_view  rd;
        t_rx_cfg_view cfg;
    } t_rx_hdr;

endpackage

// ==== rtl/hc_ctrl_pkg.sv ====
// Driver control types
`include "hc_cfg.svh"

package hc_ctrl_pkg;

    // CSR indices decoded from a configuration write
    typedef enum logic [9:0] {
        CSR_CTRL           = 10'h000,
        CSR_FROM_HOST_BASE = 10'h001,
        CSR_TO_HOST_BASE   = 10'h002,
        CSR_SREG_REQ       = 10'h003
    } t_csr_idx;

    // Bit positions of the enables within a CSR_CTRL write
    localparam int CTRL_READ_EN_BIT  = 0;
    localparam int CTRL_WRITE_EN_BIT = 1;

    // Decoded control state seen by both engines
    typedef struct packed {
        logic                      read_enable;
        logic                      write_enable;
        logic [`HC_ADDR_WIDTH-1:0] from_host_base;
        logic [`HC_ADDR_WIDTH-1:0] to_host_base;
    } t_csr_state;

    // Client status registers
    typedef logic [7:0] t_sreg_addr;
    typedef logic [`HC_DATA_WIDTH-1:0] t_sreg;

endpackage

// ==== rtl/hc_host_if.sv ====
// Registered host receive side
`include "hc_cfg.svh"

interface hc_host_if;
    import hc_bus_pkg::*;

    // Channel 0 receive where the header is decoded by whichever valid is set
    t_rx_hdr                   c0_hdr;
    logic [`HC_DATA_WIDTH-1:0] c0_data;
    logic                      c0_rd_valid;
    logic                      c0_cfg_valid;

    // Channel 1 receive only carries write acknowledgements
    logic                      c1_wr_valid;

    // Transmit flow control from the host
    logic                      c0_almost_full;
    logic                      c1_almost_full;

    // The root owns the input register stage
    modport root (output c0_hdr, c0_data, c0_rd_valid, c0_cfg_valid,
                  c1_wr_valid, c0_almost_full, c1_almost_full);

    // Every block only observes the registered values
    modport block (input c0_hdr, c0_data, c0_rd_valid, c0_cfg_valid,
                   c1_wr_valid, c0_almost_full, c1_almost_full);

endinterface

// ==== rtl/hc_csr_block.sv ====
// Configuration register block
`include "hc_cfg.svh"

module hc_csr_block
(
    input  logic                    clk,
    input  logic                    resetb,
    hc_host_if.block                host,
    output hc_ctrl_pkg::t_csr_state csr,
    output hc_ctrl_pkg::t_sreg_addr sreg_req_addr,
    output logic                    sreg_req_rdy,
    input  hc_ctrl_pkg::t_sreg      sreg_rsp,
    input  logic                    sreg_rsp_enable,
    output logic                    sreg_wr_valid,
    output hc_ctrl_pkg::t_sreg      sreg_wr_data
);
    import hc_ctrl_pkg::*;

    t_csr_idx cfg_idx;

    // Configuration writes use the CSR view of the header word
    assign cfg_idx = t_csr_idx'(host.c0_hdr.cfg.csr_idx);

    // ------------------------------------------------------------
    // Control registers and request strobes
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            csr           <= '0;
            sreg_req_rdy  <= 1'b0;
            sreg_wr_valid <= 1'b0;
        end
        else
        begin
            // The request strobe lasts a single cycle
            sreg_req_rdy <= 1'b0;
            if (host.c0_cfg_valid)
            begin
                case (cfg_idx)
                    CSR_CTRL:
                    begin
                        csr.read_enable  <= host.c0_data[CTRL_READ_EN_BIT];
                        csr.write_enable <= host.c0_data[CTRL_WRITE_EN_BIT];
                    end
                    CSR_FROM_HOST_BASE: csr.from_host_base <= host.c0_data[`HC_ADDR_WIDTH-1:0];
                    CSR_TO_HOST_BASE:   csr.to_host_base <= host.c0_data[`HC_ADDR_WIDTH-1:0];
                    CSR_SREG_REQ:       sreg_req_rdy <= 1'b1;
                    default:            ;
                endcase
            end
            // Each client answer becomes one status write toward the host
            sreg_wr_valid <= sreg_rsp_enable;
        end
    end

    // Request address and answer payload
    always_ff @(posedge clk)
    begin
        if (host.c0_cfg_valid && (cfg_idx == CSR_SREG_REQ))
            sreg_req_addr <= host.c0_data[$bits(t_sreg_addr)-1:0];
        if (sreg_rsp_enable)
            sreg_wr_data <= sreg_rsp;
    end

endmodule

// ==== rtl/hc_read_engine.sv ====
// Host to client read engine
`include "hc_cfg.svh"

module hc_read_engine
(
    input  logic                    clk,
    input  logic                    resetb,
    hc_host_if.block                host,
    input  hc_ctrl_pkg::t_csr_state csr,
    output logic                    rd_req_valid,
    output hc_bus_pkg::t_tx_hdr     rd_req_hdr,
    output hc_bus_pkg::t_line       rx_fifo_data,
    output logic                    rx_fifo_rdy,
    input  logic                    rx_fifo_enable
);
    import hc_bus_pkg::*;

    localparam int SLOT_W = $clog2(`HC_RX_BUF_DEPTH);
    localparam int IDX_W  = $clog2(`HC_RING_LINES);
    localparam int CRED_W = $clog2(`HC_RX_BUF_DEPTH + 1);

    // Client buffer, one slot per possible request in flight
    t_line                       rx_buf [`HC_RX_BUF_DEPTH];
    logic [`HC_RX_BUF_DEPTH-1:0] slot_full;
    logic [SLOT_W-1:0]           issue_slot;
    logic [SLOT_W-1:0]           pop_slot;
    logic [SLOT_W-1:0]           rsp_slot;
    // Requests outstanding plus lines waiting for the client
    logic [CRED_W-1:0]           in_use;
    logic [IDX_W-1:0]            rd_idx;
    logic                        pop;

    // A read goes out only with a free slot and the host not almost full
    assign rd_req_valid = csr.read_enable && !host.c0_almost_full &&
                          (in_use < CRED_W'(`HC_RX_BUF_DEPTH));
    assign rd_req_hdr.addr = csr.from_host_base + `HC_ADDR_WIDTH'(rd_idx);
    // Tag names the slot the response will land in
    assign rd_req_hdr.tag = `HC_TAG_WIDTH'(issue_slot);

    assign rsp_slot = host.c0_hdr.rd.tag[SLOT_W-1:0];

    // Client sees slots strictly in issue order
    assign rx_fifo_rdy  = slot_full[pop_slot];
    assign rx_fifo_data = rx_buf[pop_slot];
    assign pop          = rx_fifo_enable && rx_fifo_rdy;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            slot_full  <= '0;
            issue_slot <= '0;
            pop_slot   <= '0;
            in_use     <= '0;
            rd_idx     <= '0;
        end
        else
        begin
            if (rd_req_valid)
            begin
                issue_slot <= issue_slot + 1'b1;
                rd_idx <= (rd_idx == IDX_W'(`HC_RING_LINES - 1)) ? '0 : rd_idx + 1'b1;
            end
            // A slot is reissued only after its pop, so set and clear never collide
            if (host.c0_rd_valid)
                slot_full[rsp_slot] <= 1'b1;
            if (pop)
            begin
                slot_full[pop_slot] <= 1'b0;
                pop_slot <= pop_slot + 1'b1;
            end
            case ({rd_req_valid, pop})
                2'b10:   in_use <= in_use + 1'b1;
                2'b01:   in_use <= in_use - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (host.c0_rd_valid)
            rx_buf[rsp_slot] <= host.c0_data;
    end

endmodule

// ==== rtl/hc_write_engine.sv ====
// Client to host write engine
`include "hc_cfg.svh"

module hc_write_engine
(
    input  logic                    clk,
    input  logic                    resetb,
    hc_host_if.block                host,
    input  hc_ctrl_pkg::t_csr_state csr,
    input  hc_bus_pkg::t_line       tx_fifo_data,
    input  logic                    tx_fifo_enable,
    output logic                    tx_fifo_rdy,
    input  logic                    sreg_wr_valid,
    input  hc_ctrl_pkg::t_sreg      sreg_wr_data,
    output logic                    wr_req_valid,
    output hc_bus_pkg::t_tx_hdr     wr_req_hdr,
    output hc_bus_pkg::t_line       wr_req_data
);
    import hc_bus_pkg::*;
    import hc_ctrl_pkg::*;

    localparam int IDX_W = $clog2(`HC_RING_LINES);
    localparam int OUT_W = $clog2(`HC_MAX_WR_OUT + 1);
    // Status answers carry a tag no ring line can use
    localparam logic [`HC_TAG_WIDTH-1:0] SREG_TAG = '1;

    logic             line_valid;
    t_line            line_data;
    logic             sreg_pending;
    t_sreg            sreg_data;
    logic [IDX_W-1:0] wr_idx;
    logic [OUT_W-1:0] wr_out;
    logic             can_issue;
    logic             issue_sreg;
    logic             issue_line;
    logic             push;

    assign can_issue  = !host.c1_almost_full && (wr_out < OUT_W'(`HC_MAX_WR_OUT));
    // Status answer has fixed priority over the client line
    assign issue_sreg = sreg_pending && can_issue;
    assign issue_line = line_valid && !sreg_pending && can_issue;

    assign wr_req_valid = issue_sreg || issue_line;
    assign wr_req_hdr.addr = sreg_pending ?
                             csr.to_host_base + `HC_ADDR_WIDTH'(`HC_RING_LINES) :
                             csr.to_host_base + `HC_ADDR_WIDTH'(wr_idx);
    assign wr_req_hdr.tag = sreg_pending ? SREG_TAG : `HC_TAG_WIDTH'(wr_idx);
    assign wr_req_data = sreg_pending ? sreg_data : line_data;

    // A push waits for the previous line to leave the single holding register
    assign tx_fifo_rdy = csr.write_enable && !line_valid && !sreg_pending &&
                         (wr_out < OUT_W'(`HC_MAX_WR_OUT));
    assign push = tx_fifo_enable && tx_fifo_rdy;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            line_valid   <= 1'b0;
            sreg_pending <= 1'b0;
            wr_idx       <= '0;
            wr_out       <= '0;
        end
        else
        begin
            if (issue_line)
            begin
                line_valid <= 1'b0;
                wr_idx <= (wr_idx == IDX_W'(`HC_RING_LINES - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (push)
                line_valid <= 1'b1;
            if (issue_sreg)
                sreg_pending <= 1'b0;
            if (sreg_wr_valid)
                sreg_pending <= 1'b1;
            // Acks only follow issued writes so the count cannot underflow
            case ({wr_req_valid, host.c1_wr_valid})
                2'b10:   wr_out <= wr_out + 1'b1;
                2'b01:   wr_out <= wr_out - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            line_data <= tx_fifo_data;
        if (sreg_wr_valid)
            sreg_data <= sreg_wr_data;
    end

endmodule

// ==== rtl/hc_root.sv ====
// Host channel driver top
`include "hc_cfg.svh"

module hc_root
(
    input  logic                                    clk,
    input  logic                                    resetb,
    // Host link, channel 0 and channel 1
    input  logic [$bits(hc_bus_pkg::t_rx_hdr)-1:0]  c0_rx_hdr,
    input  logic [`HC_DATA_WIDTH-1:0]               c0_rx_data,
    input  logic                                    c0_rx_rd_valid,
    input  logic                                    c0_rx_cfg_valid,
    input  logic                                    c1_rx_wr_valid,
    input  logic                                    c0_tx_almost_full,
    input  logic                                    c1_tx_almost_full,
    output logic [$bits(hc_bus_pkg::t_tx_hdr)-1:0]  c0_tx_hdr,
    output logic                                    c0_tx_rd_valid,
    output logic [$bits(hc_bus_pkg::t_tx_hdr)-1:0]  c1_tx_hdr,
    output logic [`HC_DATA_WIDTH-1:0]               c1_tx_data,
    output logic                                    c1_tx_wr_valid,
    // Client receive and transmit FIFOs
    output logic [`HC_DATA_WIDTH-1:0]               rx_fifo_data,
    output logic                                    rx_fifo_rdy,
    input  logic                                    rx_fifo_enable,
    input  logic [`HC_DATA_WIDTH-1:0]               tx_fifo_data,
    input  logic                                    tx_fifo_enable,
    output logic                                    tx_fifo_rdy,
    // Client status registers used for debug
    output logic [$bits(hc_ctrl_pkg::t_sreg_addr)-1:0] sreg_req_addr,
    output logic                                    sreg_req_rdy,
    input  logic [`HC_DATA_WIDTH-1:0]               sreg_rsp,
    input  logic                                    sreg_rsp_enable
);
    import hc_bus_pkg::*;
    import hc_ctrl_pkg::*;

    hc_host_if host ();

    t_csr_state csr;
    logic       rd_req_valid;
    t_tx_hdr    rd_req_hdr;
    logic       wr_req_valid;
    t_tx_hdr    wr_req_hdr;
    t_line      wr_req_data;
    logic       sreg_wr_valid;
    t_sreg      sreg_wr_data;

    // ------------------------------------------------------------
    // Input register stage from the host link
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            host.c0_rd_valid    <= 1'b0;
            host.c0_cfg_valid   <= 1'b0;
            host.c1_wr_valid    <= 1'b0;
            host.c0_almost_full <= 1'b0;
            host.c1_almost_full <= 1'b0;
        end
        else
        begin
            host.c0_rd_valid    <= c0_rx_rd_valid;
            host.c0_cfg_valid   <= c0_rx_cfg_valid;
            host.c1_wr_valid    <= c1_rx_wr_valid;
            host.c0_almost_full <= c0_tx_almost_full;
            host.c1_almost_full <= c1_tx_almost_full;
        end
    end

    always_ff @(posedge clk)
    begin
        host.c0_hdr  <= c0_rx_hdr;
        host.c0_data <= c0_rx_data;
    end

    // ------------------------------------------------------------
    // Output register stage so the host sees only flopped requests
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            c0_tx_rd_valid <= 1'b0;
            c1_tx_wr_valid <= 1'b0;
        end
        else
        begin
            c0_tx_rd_valid <= rd_req_valid;
            c1_tx_wr_valid <= wr_req_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        c0_tx_hdr  <= rd_req_hdr;
        c1_tx_hdr  <= wr_req_hdr;
        c1_tx_data <= wr_req_data;
    end

    // Control block and the two memory-mapped FIFOs
    hc_csr_block csr_block (
        .clk             (clk),
        .resetb          (resetb),
        .host            (host),
        .csr             (csr),
        .sreg_req_addr   (sreg_req_addr),
        .sreg_req_rdy    (sreg_req_rdy),
        .sreg_rsp        (sreg_rsp),
        .sreg_rsp_enable (sreg_rsp_enable),
        .sreg_wr_valid   (sreg_wr_valid),
        .sreg_wr_data    (sreg_wr_data)
    );

    hc_read_engine read_engine (
        .clk            (clk),
        .resetb         (resetb),
        .host           (host),
        .csr            (csr),
        .rd_req_valid   (rd_req_valid),
        .rd_req_hdr     (rd_req_hdr),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_rdy    (rx_fifo_rdy),
        .rx_fifo_enable (rx_fifo_enable)
    );

    hc_write_engine write_engine (
        .clk            (clk),
        .resetb         (resetb),
        .host           (host),
        .csr            (csr),
        .tx_fifo_data   (tx_fifo_data),
        .tx_fifo_enable (tx_fifo_enable),
        .tx_fifo_rdy    (tx_fifo_rdy),
        .sreg_wr_valid  (sreg_wr_valid),
        .sreg_wr_data   (sreg_wr_data),
        .wr_req_valid   (wr_req_valid),
        .wr_req_hdr     (wr_req_hdr),
        .wr_req_data    (wr_req_data)
    );

endmodule

// ==== testbench/hc_clk_gen.sv ====
// Testbench clock and reset
module hc_clk_gen
#(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
)
(
    output logic clk,
    output logic resetb
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset is released on a rising edge, like every other testbench input
    initial
    begin
        resetb = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetb <= 1'b1;
    end

endmodule

// ==== testbench/hc_tb.sv ====
// Host channel driver testbench
`include "hc_cfg.svh"

module hc_tb;
    import hc_bus_pkg::*;
    import hc_ctrl_pkg::*;

    localparam int N_LINES    = 48;
    localparam int PEND_SLOTS = 8;
    localparam logic [31:0] FROM_BASE = 32'h0001_2340;
    localparam logic [31:0] TO_BASE   = 32'h0004_5600;
    // Reset, config, two status requests, both streams and a margin
    localparam int TIMEOUT_CYCLES = 10 + 8 + 2 * 40 + N_LINES * 10 + 200;

    logic clk;
    logic resetb;
    logic [15:0] c0_rx_hdr;
    logic [63:0] c0_rx_data;
    logic c0_rx_rd_valid;
    logic c0_rx_cfg_valid;
    logic c1_rx_wr_valid = 1'b0;
    logic c0_tx_almost_full = 1'b0;
    logic c1_tx_almost_full = 1'b0;
    logic [$bits(t_tx_hdr)-1:0] c0_tx_hdr;
    logic c0_tx_rd_valid;
    logic [$bits(t_tx_hdr)-1:0] c1_tx_hdr;
    logic [63:0] c1_tx_data;
    logic c1_tx_wr_valid;
    logic [63:0] rx_fifo_data;
    logic rx_fifo_rdy;
    logic rx_fifo_enable = 1'b0;
    logic [63:0] tx_fifo_data = '0;
    logic tx_fifo_enable = 1'b0;
    logic tx_fifo_rdy;
    logic [7:0] sreg_req_addr;
    logic sreg_req_rdy;
    logic [63:0] sreg_rsp = '0;
    logic sreg_rsp_enable = 1'b0;

    // Channel 0 receive sources merged below
    logic cfg_valid = 1'b0;
    logic [15:0] cfg_hdr = '0;
    logic [63:0] cfg_data = '0;
    logic rsp_valid = 1'b0;
    logic [15:0] rsp_hdr = '0;
    logic [63:0] rsp_data = '0;

    // Host read model with one entry per response still owed
    logic pend_valid [PEND_SLOTS];
    logic [2:0] pend_wait [PEND_SLOTS];
    logic [7:0] pend_tag [PEND_SLOTS];
    logic [31:0] pend_addr [PEND_SLOTS];
    int ack_owed = 0;

    logic [31:0] lfsr_state = 32'h0b0c2f80;
    logic [15:0] rnd = '0;
    logic stream_go = 1'b0;
    logic run_done = 1'b0;
    logic sreg_busy = 1'b0;
    logic [3:0] sreg_wait = '0;
    logic [7:0] sreg_addr_l = '0;
    logic [63:0] exp_sreg = '0;

    // Scoreboard counters
    int rd_issued = 0;
    int rd_popped = 0;
    int push_cnt = 0;
    int wr_cnt = 0;
    int sreg_answers = 0;
    int sreg_writes = 0;
    int cycle_cnt = 0;
    int err_cnt = 0;
    int err_seen = 0;
    int tests_done = 0;

    t_tx_hdr c1_hdr_t;
    t_tx_hdr c0_hdr_t;
    logic rx_pop;
    logic tx_push;
    logic c1_is_status;
    logic sreg_cfg_in;
    logic [63:0] exp_rd_data;
    logic [31:0] exp_wr_addr;
    logic [63:0] exp_wr_data;

    // Host memory holds the address in the upper half and its inverse below
    function automatic logic [63:0] line_pattern(input logic [31:0] a);
        return {a, ~a};
    endfunction

    // Client line number k as the client pushes it
    function automatic logic [63:0] tx_line(input int k);
        logic [31:0] w;
        w = 32'(k);
        return {32'h7c00_0000 ^ w, w * 32'h9e37_79b9};
    endfunction

    function automatic logic [63:0] sreg_answer(input logic [7:0] a);
        return {a, ~a, a, ~a, a, ~a, a, ~a};
    endfunction

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic log_error(input string msg);
        err_cnt = err_cnt + 1;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    task automatic report_test(input string name);
        $display("Test %0d (%s) finished, %0d failed checks", tests_done + 1, name,
                 err_cnt - err_seen);
        err_seen = err_cnt;
        tests_done = tests_done + 1;
    endtask

    task automatic cfg_write(input t_csr_idx idx, input logic [63:0] data);
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_hdr <= {6'b0, idx};
        cfg_data <= data;
        @(posedge clk);
        cfg_valid <= 1'b0;
    endtask

    task automatic finish_run;
        $display("Tests run: %0d, failed checks: %0d", tests_done, err_cnt);
        if (err_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    hc_clk_gen clk_gen (.clk(clk), .resetb(resetb));

    hc_root UUT (
        .clk               (clk),
        .resetb            (resetb),
        .c0_rx_hdr         (c0_rx_hdr),
        .c0_rx_data        (c0_rx_data),
        .c0_rx_rd_valid    (c0_rx_rd_valid),
        .c0_rx_cfg_valid   (c0_rx_cfg_valid),
        .c1_rx_wr_valid    (c1_rx_wr_valid),
        .c0_tx_almost_full (c0_tx_almost_full),
        .c1_tx_almost_full (c1_tx_almost_full),
        .c0_tx_hdr         (c0_tx_hdr),
        .c0_tx_rd_valid    (c0_tx_rd_valid),
        .c1_tx_hdr         (c1_tx_hdr),
        .c1_tx_data        (c1_tx_data),
        .c1_tx_wr_valid    (c1_tx_wr_valid),
        .rx_fifo_data      (rx_fifo_data),
        .rx_fifo_rdy       (rx_fifo_rdy),
        .rx_fifo_enable    (rx_fifo_enable),
        .tx_fifo_data      (tx_fifo_data),
        .tx_fifo_enable    (tx_fifo_enable),
        .tx_fifo_rdy       (tx_fifo_rdy),
        .sreg_req_addr     (sreg_req_addr),
        .sreg_req_rdy      (sreg_req_rdy),
        .sreg_rsp          (sreg_rsp),
        .sreg_rsp_enable   (sreg_rsp_enable)
    );

    // Config writes and read responses never overlap in this sequence
    assign c0_rx_rd_valid  = rsp_valid;
    assign c0_rx_cfg_valid = cfg_valid;
    assign c0_rx_hdr  = cfg_valid ? cfg_hdr : rsp_hdr;
    assign c0_rx_data = cfg_valid ? cfg_data : rsp_data;

    assign c0_hdr_t = c0_tx_hdr;
    assign c1_hdr_t = c1_tx_hdr;
    assign rx_pop = rx_fifo_enable && rx_fifo_rdy;
    assign tx_push = tx_fifo_enable && tx_fifo_rdy;
    assign c1_is_status = c1_hdr_t.addr == TO_BASE + 32'(`HC_RING_LINES);
    assign sreg_cfg_in = c0_rx_cfg_valid && (c0_rx_hdr[9:0] == CSR_SREG_REQ);
    // Expected lines follow the ring order counted so far
    assign exp_rd_data = line_pattern(FROM_BASE + 32'(rd_popped % `HC_RING_LINES));
    assign exp_wr_addr = TO_BASE + 32'(wr_cnt % `HC_RING_LINES);
    assign exp_wr_data = tx_line(wr_cnt);

    // ------------------------------------------------------------
    // Random source with sixteen LFSR steps per cycle
    // ------------------------------------------------------------
    always @(posedge clk)
    begin
        logic [31:0] s;
        logic [15:0] bits;
        s = lfsr_state;
        for (int b = 0; b < 16; b++)
        begin
            bits[b] = s[0];
            s = lfsr_next(s);
        end
        lfsr_state <= s;
        rnd <= bits;
    end

    // Host model that answers reads after random waits so returns can reorder
    always @(posedge clk)
    begin
        logic sent;
        logic placed;
        sent = 1'b0;
        placed = 1'b0;
        rsp_valid <= 1'b0;
        c1_rx_wr_valid <= 1'b0;
        if (!resetb)
        begin
            for (int i = 0; i < PEND_SLOTS; i++)
                pend_valid[i] = 1'b0;
            ack_owed = 0;
            c0_tx_almost_full <= 1'b0;
            c1_tx_almost_full <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < PEND_SLOTS; i++)
            begin
                if (!sent && pend_valid[i] && pend_wait[i] == 3'd0)
                begin
                    rsp_valid <= 1'b1;
                    rsp_hdr <= {8'h00, pend_tag[i]};
                    rsp_data <= line_pattern(pend_addr[i]);
                    pend_valid[i] = 1'b0;
                    sent = 1'b1;
                end
                else if (pend_valid[i] && pend_wait[i] != 3'd0)
                    pend_wait[i] = pend_wait[i] - 3'd1;
            end
            for (int i = 0; i < PEND_SLOTS; i++)
            begin
                if (c0_tx_rd_valid && !placed && !pend_valid[i])
                begin
                    pend_valid[i] = 1'b1;
                    pend_wait[i] = rnd[2:0];
                    pend_tag[i] = c0_hdr_t.tag;
                    pend_addr[i] = c0_hdr_t.addr;
                    placed = 1'b1;
                end
            end
            // Writes are acked one at a time about every other cycle
            if (ack_owed > 0 && rnd[7])
            begin
                c1_rx_wr_valid <= 1'b1;
                ack_owed = ack_owed - 1;
            end
            if (c1_tx_wr_valid)
                ack_owed = ack_owed + 1;
            c0_tx_almost_full <= (rnd[4:3] == 2'b00);
            c1_tx_almost_full <= (rnd[6:5] == 2'b00);
        end
    end

    // Client model with at most one pop and one push every other cycle
    always @(posedge clk)
    begin
        if (!resetb)
        begin
            rx_fifo_enable <= 1'b0;
            tx_fifo_enable <= 1'b0;
        end
        else
        begin
            rx_fifo_enable <= stream_go && rx_fifo_rdy && !rx_fifo_enable && rnd[8];
            tx_fifo_enable <= stream_go && tx_fifo_rdy && !tx_fifo_enable && rnd[9] &&
                              (push_cnt < N_LINES);
        end
        tx_fifo_data <= tx_line(push_cnt);
    end

    // Client status registers answer each request once after a random wait
    always @(posedge clk)
    begin
        sreg_rsp_enable <= 1'b0;
        if (!resetb)
            sreg_busy = 1'b0;
        else if (sreg_req_rdy)
        begin
            sreg_busy = 1'b1;
            sreg_addr_l = sreg_req_addr;
            sreg_wait = rnd[13:10];
        end
        else if (sreg_busy && sreg_wait == 4'd0)
        begin
            sreg_rsp_enable <= 1'b1;
            sreg_rsp <= sreg_answer(sreg_addr_l);
            exp_sreg <= sreg_answer(sreg_addr_l);
            sreg_answers <= sreg_answers + 1;
            sreg_busy = 1'b0;
        end
        else if (sreg_busy)
            sreg_wait = sreg_wait - 4'd1;
    end

    always @(posedge clk)
    begin
        if (c0_tx_rd_valid)
            rd_issued <= rd_issued + 1;
        if (rx_pop)
            rd_popped <= rd_popped + 1;
        if (tx_push)
            push_cnt <= push_cnt + 1;
        if (c1_tx_wr_valid && !c1_is_status)
            wr_cnt <= wr_cnt + 1;
        if (c1_tx_wr_valid && c1_is_status)
            sreg_writes <= sreg_writes + 1;
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    reset_idle_check: assert property (@(posedge clk) $rose(resetb) |->
        !c0_tx_rd_valid && !c1_tx_wr_valid && !rx_fifo_rdy && !sreg_req_rdy && !tx_fifo_rdy)
        else log_error("outputs not idle after reset");
    rd_order_check: assert property (@(posedge clk) disable iff (!resetb)
        rx_pop |-> rx_fifo_data == exp_rd_data)
        else log_error("client line does not match the ring in order");
    rd_credit_check: assert property (@(posedge clk) disable iff (!resetb)
        (rd_issued - rd_popped) <= `HC_RX_BUF_DEPTH)
        else log_error("reads in flight plus buffered lines exceed the buffer");
    c0_full_check: assert property (@(posedge clk) disable iff (!resetb)
        $past(c0_tx_almost_full, 2) |-> !c0_tx_rd_valid)
        else log_error("read request while channel 0 almost full");
    c1_full_check: assert property (@(posedge clk) disable iff (!resetb)
        $past(c1_tx_almost_full, 2) |-> !c1_tx_wr_valid)
        else log_error("write request while channel 1 almost full");
    wr_line_check: assert property (@(posedge clk) disable iff (!resetb)
        c1_tx_wr_valid && !c1_is_status |->
        wr_cnt < push_cnt && c1_hdr_t.addr == exp_wr_addr && c1_tx_data == exp_wr_data)
        else log_error("ring write with wrong address, data or order");
    sreg_pulse_check: assert property (@(posedge clk) disable iff (!resetb)
        sreg_req_rdy == $past(sreg_cfg_in, 2))
        else log_error("status request strobe not two edges after its config write");
    sreg_addr_check: assert property (@(posedge clk) disable iff (!resetb)
        sreg_req_rdy |-> sreg_req_addr == $past(c0_rx_data[7:0], 2))
        else log_error("status request address differs from the written one");
    sreg_write_check: assert property (@(posedge clk) disable iff (!resetb)
        c1_tx_wr_valid && c1_is_status |-> sreg_writes < sreg_answers && c1_tx_data == exp_sreg)
        else log_error("status answer written wrong or more than once");
    end_count_check: assert property (@(posedge clk) disable iff (!resetb)
        run_done |-> wr_cnt == push_cnt && sreg_answers == 2 && sreg_writes == sreg_answers)
        else log_error("write counts at end of run do not match");

    // Run limit counted in clock cycles
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        wait (resetb === 1'b1);
        repeat (4) @(posedge clk);
        report_test("reset values");

        cfg_write(CSR_FROM_HOST_BASE, 64'(FROM_BASE));
        cfg_write(CSR_TO_HOST_BASE, 64'(TO_BASE));
        cfg_write(CSR_SREG_REQ, 64'h3c);
        wait (sreg_writes == 1);
        cfg_write(CSR_SREG_REQ, 64'hc5);
        wait (sreg_writes == 2);
        report_test("status register");

        // Enable both engines, then let the client run
        cfg_write(CSR_CTRL, 64'h3);
        @(posedge clk);
        stream_go <= 1'b1;
        wait (rd_popped >= N_LINES);
        report_test("read stream");
        wait (wr_cnt >= N_LINES);
        report_test("write stream");
        @(posedge clk);
        run_done <= 1'b1;
        repeat (2) @(posedge clk);
        report_test("back-pressure and counts");
        finish_run();
    end

endmodule

// ==== hc_driver.f ====
+incdir+rtl
rtl/hc_bus_pkg.sv
rtl/hc_ctrl_pkg.sv
rtl/hc_host_if.sv
rtl/hc_csr_block.sv
rtl/hc_read_engine.sv
rtl/hc_write_engine.sv
rtl/hc_root.sv
testbench/hc_clk_gen.sv
testbench/hc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the host channel driver testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f hc_driver.f --top-module hc_tb -o hc_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/hc_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    exit 0
fi
exit 1
